// File: rtl/div_params.svh
/*
 * division unit parameters
 * operand width and depth of the operand buffer
 */

`ifndef DIV_PARAMS_SVH
`define DIV_PARAMS_SVH

// width of dividend, divisor, quotient and remainder
`define DIV_BITS 8

// operand pairs held in the buffer
// must stay a power of two, pointers wrap on their own
`define DIV_FIFO_DEPTH 4

`endif

// File: rtl/div_pkg.sv
/*
 * division unit package
 * shared word type and divider state encoding
 */

`include "div_params.svh"

package div_pkg;

	// unsigned operand and result word
	typedef logic [`DIV_BITS - 1 : 0] t_word;

	// divider states
	typedef enum logic [1 : 0] {
		// remainder follows dividend, wait for start
		load,
		// compare remainder against divisor
		check_sub,
		// remove one divisor from remainder
		sub,
		// result held until next start
		finished
	} t_div_state;

endpackage

// File: rtl/ripple_carry_adder.sv
/*
 * ripple carry adder
 * one full adder per bit, carry out of the top bit is not formed
 */

`timescale 1ns/10ps

module ripple_carry_adder (
	input div_pkg::t_word in_a,
	input div_pkg::t_word in_b,
	output div_pkg::t_word sum
);

	localparam int BITS = $bits(div_pkg::t_word);

	// carry into each bit position
	logic [BITS - 1 : 0] carry;

	// no carry into the lowest bit
	assign carry[0] = 1'b0;

	genvar i;
	generate
		for (i = 0; i < BITS; i++) begin : gen_bit
			// sum bit
			assign sum[i] = in_a[i] ^ in_b[i] ^ carry[i];

			// carry to next bit, top bit drops it
			if (i < BITS - 1) begin : gen_carry
				assign carry[i + 1] = (in_a[i] & in_b[i]) |
					(carry[i] & (in_a[i] ^ in_b[i]));
			end
		end
	endgenerate

endmodule

// File: rtl/divider.sv
/*
 * repeated subtraction divider
 * subtracts the divisor until the remainder is below it,
 * counting the subtractions as the quotient
 */

`timescale 1ns/10ps

module divider (
	input logic in_clk,
	input logic in_rst,
	input logic start,
	input div_pkg::t_word a,
	input div_pkg::t_word b,
	output div_pkg::t_word quot,
	output div_pkg::t_word rem,
	output logic finished
);

	div_pkg::t_div_state state;
	div_pkg::t_div_state state_next;

	// running quotient and remainder
	div_pkg::t_word quotient;
	div_pkg::t_word quotient_next;
	div_pkg::t_word remainder;
	div_pkg::t_word remainder_next;

	// two's complement of the divisor
	div_pkg::t_word b_neg;
	// remainder minus divisor
	div_pkg::t_word remainder_sub;

	assign b_neg = ~b + 1'b1;

	// subtraction as addition of the negated divisor
	ripple_carry_adder sub_adder (
		.in_a(remainder),
		.in_b(b_neg),
		.sum(remainder_sub)
	);

	assign quot = quotient;
	assign rem = remainder;
	assign finished = (state == div_pkg::finished);

	// state register
	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			state <= div_pkg::load;
		end else begin
			state <= state_next;
		end
	end

	// result registers, refilled in load
	always_ff @(posedge in_clk) begin
		quotient <= quotient_next;
		remainder <= remainder_next;
	end

	// next state and datapath
	always_comb begin
		state_next = state;
		quotient_next = quotient;
		remainder_next = remainder;

		unique case (state)
			div_pkg::load: begin
				// dividend becomes the starting remainder
				quotient_next = '0;
				remainder_next = a;
				if (start) begin
					state_next = div_pkg::check_sub;
				end
			end

			div_pkg::check_sub: begin
				// one more subtraction fits?
				if (remainder >= b) begin
					state_next = div_pkg::sub;
				end else begin
					state_next = div_pkg::finished;
				end
			end

			div_pkg::sub: begin
				remainder_next = remainder_sub;
				quotient_next = quotient + 1'b1;
				state_next = div_pkg::check_sub;
			end

			div_pkg::finished: begin
				// hold result, next start rearms
				if (start) begin
					state_next = div_pkg::load;
				end
			end

			default: begin
				state_next = div_pkg::load;
			end
		endcase
	end

endmodule

// File: rtl/operand_fifo.sv
/*
 * operand buffer
 * circular buffer of dividend and divisor pairs,
 * head pair visible while not empty
 */

`timescale 1ns/10ps

`include "div_params.svh"

module operand_fifo #(
	parameter int DEPTH = `DIV_FIFO_DEPTH
) (
	input logic in_clk,
	input logic in_rst,
	input logic push,
	input logic pop,
	input div_pkg::t_word push_a,
	input div_pkg::t_word push_b,
	output div_pkg::t_word head_a,
	output div_pkg::t_word head_b,
	output logic empty,
	output logic full
);

	localparam int PTR_BITS = $clog2(DEPTH);

	// pair storage
	div_pkg::t_word mem_a [DEPTH];
	div_pkg::t_word mem_b [DEPTH];

	logic [PTR_BITS - 1 : 0] wr_ptr;
	logic [PTR_BITS - 1 : 0] rd_ptr;
	// occupancy, one bit wider than the pointers
	logic [PTR_BITS : 0] count;

	logic do_push;
	logic do_pop;

	// drop push when full, pop when empty
	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;

	assign empty = (count == '0);
	assign full = (count == (PTR_BITS + 1)'(DEPTH));

	assign head_a = mem_a[rd_ptr];
	assign head_b = mem_b[rd_ptr];

	// storage write
	always_ff @(posedge in_clk) begin
		if (do_push) begin
			mem_a[wr_ptr] <= push_a;
			mem_b[wr_ptr] <= push_b;
		end
	end

	// pointers and count
	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// simultaneous push and pop keeps the count
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// File: rtl/div_issue.sv
/*
 * issue controller
 * takes one operand pair at a time, catches zero divisors,
 * starts the divider and emits a one-cycle result strobe
 */

`timescale 1ns/10ps

module div_issue (
	input logic in_clk,
	input logic in_rst,
	input logic empty,
	input logic finished,
	input div_pkg::t_word head_a,
	input div_pkg::t_word head_b,
	input div_pkg::t_word quot,
	input div_pkg::t_word rem,
	output logic pop,
	output logic start,
	output logic valid,
	output logic div_zero,
	output div_pkg::t_word a,
	output div_pkg::t_word b,
	output div_pkg::t_word res_quot,
	output div_pkg::t_word res_rem
);

	// idle waits for a pair, issue decides, busy waits for the divider
	typedef enum logic [1 : 0] {
		idle,
		issue,
		busy
	} t_issue_state;

	t_issue_state state;

	logic zero_div;

	assign zero_div = (b == '0);

	// pop and capture in the same cycle
	assign pop = (state == idle) & ~empty;

	// first start launches, second start rearms the divider
	assign start = ((state == issue) & ~zero_div) | ((state == busy) & finished);

	assign div_zero = (state == issue) & zero_div;
	assign valid = div_zero | ((state == busy) & finished);

	// zero divisor gives all ones and the dividend back
	assign res_quot = div_zero ? '1 : quot;
	assign res_rem = div_zero ? a : rem;

	// operand registers, held until the result goes out
	always_ff @(posedge in_clk) begin
		if (pop) begin
			a <= head_a;
			b <= head_b;
		end
	end

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			state <= idle;
		end else begin
			unique case (state)
				idle: if (pop) state <= issue;
				issue: state <= zero_div ? idle : busy;
				busy: if (finished) state <= idle;
				default: state <= idle;
			endcase
		end
	end

endmodule

// File: rtl/div_unit.sv
/*
 * integer division unit
 * operand buffer feeding an issue controller and a subtraction divider
 */

`timescale 1ns/10ps

module div_unit (
	input logic in_clk,
	input logic in_rst,
	input logic in_push,
	input div_pkg::t_word in_a,
	input div_pkg::t_word in_b,
	output logic out_full,
	output logic out_valid,
	output logic out_div_zero,
	output div_pkg::t_word out_quot,
	output div_pkg::t_word out_rem
);

	// buffer to controller
	logic pop;
	logic empty;
	div_pkg::t_word head_a;
	div_pkg::t_word head_b;

	// controller to divider
	logic start;
	logic finished;
	div_pkg::t_word op_a;
	div_pkg::t_word op_b;
	div_pkg::t_word quot;
	div_pkg::t_word rem;

	operand_fifo operand_fifo_inst (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.push(in_push),
		.pop(pop),
		.push_a(in_a),
		.push_b(in_b),
		.head_a(head_a),
		.head_b(head_b),
		.empty(empty),
		.full(out_full)
	);

	div_issue div_issue_inst (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.empty(empty),
		.finished(finished),
		.head_a(head_a),
		.head_b(head_b),
		.quot(quot),
		.rem(rem),
		.pop(pop),
		.start(start),
		.valid(out_valid),
		.div_zero(out_div_zero),
		.a(op_a),
		.b(op_b),
		.res_quot(out_quot),
		.res_rem(out_rem)
	);

	divider divider_inst (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.start(start),
		.a(op_a),
		.b(op_b),
		.quot(quot),
		.rem(rem),
		.finished(finished)
	);

endmodule

// File: verification/div_unit_properties.sv
/*
 * division unit properties
 * concurrent checks on the top-level result and status ports
 */

`timescale 1ns/10ps

module div_unit_properties (
	input logic in_clk,
	input logic in_rst,
	input logic out_valid,
	input logic out_full,
	input logic out_div_zero,
	input div_pkg::t_word out_quot,
	input div_pkg::t_word out_rem,
	input div_pkg::t_div_state div_state,
	input div_pkg::t_word exp_b
);

	// result strobe lasts exactly one cycle
	valid_single_cycle: assert property (@(posedge in_clk) disable iff (in_rst)
		out_valid |=> !out_valid)
		else $error("out_valid high for two consecutive cycles");

	// quiet outputs and divider back in load once reset has been seen
	reset_quiet: assert property (@(posedge in_clk)
		in_rst |=> (!out_valid && !out_full && !out_div_zero && div_state == div_pkg::load))
		else $error("outputs or divider state not cleared after reset");

	// zero divisor result is all ones
	div_zero_quot: assert property (@(posedge in_clk) disable iff (in_rst)
		out_div_zero |-> (out_quot == '1))
		else $error("out_div_zero without an all-ones quotient");

	// remainder of a real division is below its divisor
	rem_below_divisor: assert property (@(posedge in_clk) disable iff (in_rst)
		(out_valid && !out_div_zero) |-> (out_rem < exp_b))
		else $error("remainder not below the divisor");

endmodule

// File: verification/div_unit_tb.sv
/*
 * division unit testbench
 * pushes operand pairs from the vector file in groups,
 * checks every result in push order against the division rules
 */

`timescale 1ns/10ps

`include "div_params.svh"

module div_unit_tb;

	logic in_clk;
	logic in_rst;
	logic in_push;
	div_pkg::t_word in_a;
	div_pkg::t_word in_b;
	logic out_full;
	logic out_valid;
	logic out_div_zero;
	div_pkg::t_word out_quot;
	div_pkg::t_word out_rem;

	// divisor of the oldest outstanding pair, seen by the properties
	div_pkg::t_word exp_divisor;

	// vectors from the file
	int vec_group[$];
	div_pkg::t_word vec_a[$];
	div_pkg::t_word vec_b[$];

	// accepted pairs still waiting for a result
	div_pkg::t_word exp_a_q[$];
	div_pkg::t_word exp_b_q[$];

	int pass_count = 0;
	int fail_count = 0;
	int error_count = 0;
	int result_count = 0;
	int accepted_count = 0;
	// accepted pairs thrown away by a reset
	int flushed_count = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	div_unit div_unit_inst (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.in_push(in_push),
		.in_a(in_a),
		.in_b(in_b),
		.out_full(out_full),
		.out_valid(out_valid),
		.out_div_zero(out_div_zero),
		.out_quot(out_quot),
		.out_rem(out_rem)
	);

	bind div_unit div_unit_properties div_unit_properties_inst (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.out_valid(out_valid),
		.out_full(out_full),
		.out_div_zero(out_div_zero),
		.out_quot(out_quot),
		.out_rem(out_rem),
		.div_state(divider_inst.state),
		.exp_b(div_unit_tb.exp_divisor)
	);

	initial in_clk = 1'b0;
	always #50 in_clk = ~in_clk;

	// expected results straight from the division rules
	function automatic div_pkg::t_word expected_quot(div_pkg::t_word a, div_pkg::t_word b);
		if (b == '0) begin
			return '1;
		end
		return a / b;
	endfunction

	function automatic div_pkg::t_word expected_rem(div_pkg::t_word a, div_pkg::t_word b);
		if (b == '0) begin
			return a;
		end
		return a % b;
	endfunction

	task automatic compare_word(input string what, input div_pkg::t_word got,
		input div_pkg::t_word expected);
		if (got !== expected) begin
			$display("error at %0t: %s is %0h, expected %0h", $time, what, got, expected);
			error_count++;
		end
	endtask

	task automatic compare_flag(input string what, input logic got, input logic expected);
		if (got !== expected) begin
			$display("error at %0t: %s is %0b, expected %0b", $time, what, got, expected);
			error_count++;
		end
	endtask

	// reset for 10 cycles, pairs still in flight are flushed
	task automatic apply_reset();
		@(posedge in_clk);
		#1;
		in_rst = 1'b1;
		in_push = 1'b0;
		repeat (10) @(posedge in_clk);
		#1;
		flushed_count += exp_a_q.size();
		exp_a_q.delete();
		exp_b_q.delete();
		in_rst = 1'b0;
	endtask

	// back to back pushes, holding off while the buffer is full
	task automatic push_group(input int first, input int last);
		int idx;
		idx = first;
		while (idx <= last) begin
			@(posedge in_clk);
			#1;
			if (out_full) begin
				in_push = 1'b0;
			end else begin
				in_push = 1'b1;
				in_a = vec_a[idx];
				in_b = vec_b[idx];
				exp_a_q.push_back(vec_a[idx]);
				exp_b_q.push_back(vec_b[idx]);
				accepted_count++;
				idx++;
			end
		end
		@(posedge in_clk);
		#1;
		in_push = 1'b0;
	endtask

	// read vectors, cross-check the listed results against the rules
	task automatic read_vectors();
		int fd;
		int status;
		int line_no;
		int grp;
		div_pkg::t_word va;
		div_pkg::t_word vb;
		div_pkg::t_word fq;
		div_pkg::t_word fr;
		logic fz;
		string line;
		line_no = 0;
		fd = $fopen("verification/div_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open the vector file verification/div_vectors.txt");
			fail_count++;
			return;
		end
		while (!$feof(fd)) begin
			status = $fgets(line, fd);
			line_no++;
			if (status > 0 && line[0] != "#") begin
				status = $sscanf(line, "%h %h %h %h %h %h", grp, va, vb, fq, fr, fz);
				if (status == 6) begin
					vec_group.push_back(grp);
					vec_a.push_back(va);
					vec_b.push_back(vb);
					if (fq !== expected_quot(va, vb) || fr !== expected_rem(va, vb) ||
						fz !== (vb == '0)) begin
						$display("vector file line %0d lists results that break the rules",
							line_no);
						fail_count++;
					end
				end
			end
		end
		$fclose(fd);
	endtask

	// drive the divisor of the oldest pair like any other input
	always @(posedge in_clk) begin
		#1;
		exp_divisor = (exp_b_q.size() != 0) ? exp_b_q[0] : '0;
	end

	// result monitor, mid-cycle where outputs are settled
	always @(negedge in_clk) begin
		div_pkg::t_word op_a;
		div_pkg::t_word op_b;
		int errs_before;
		if (out_valid === 1'b1) begin
			result_count++;
			if (exp_a_q.size() == 0) begin
				$display("result strobe at %0t with no operand pair outstanding", $time);
				fail_count++;
			end else begin
				op_a = exp_a_q.pop_front();
				op_b = exp_b_q.pop_front();
				errs_before = error_count;
				compare_word("quotient", out_quot, expected_quot(op_a, op_b));
				compare_word("remainder", out_rem, expected_rem(op_a, op_b));
				compare_flag("div_zero", out_div_zero, op_b == '0);
				if (error_count == errs_before) begin
					pass_count++;
				end else begin
					fail_count++;
				end
				$display("test %0d: %0h / %0h gives quot %0h rem %0h div_zero %0b, %s",
					result_count, op_a, op_b, out_quot, out_rem, out_div_zero,
					(error_count == errs_before) ? "ok" : "mismatch");
			end
		end
	end

	// timeout on the worst case quotient for every vector
	always @(posedge in_clk) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("timeout: run still busy after %0d cycles", cycle_limit);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	initial begin
		int first;
		int last;
		in_rst = 1'b1;
		in_push = 1'b0;
		in_a = '0;
		in_b = '0;
		exp_divisor = '0;
		read_vectors();
		cycle_limit = vec_a.size() * (2 * (1 << `DIV_BITS) + 10);
		first = 0;
		while (first < vec_a.size()) begin
			last = first;
			while (last + 1 < vec_a.size() && vec_group[last + 1] == vec_group[first]) begin
				last++;
			end
			// later groups: part of the group in flight when reset hits
			if (first > 0) begin
				push_group(first, (last < first + 3) ? last : first + 3);
			end
			// reset, then a few idle cycles with no strobe allowed
			apply_reset();
			repeat (4) @(posedge in_clk);
			push_group(first, last);
			while (exp_a_q.size() != 0) begin
				@(posedge in_clk);
			end
			first = last + 1;
		end
		repeat (4) @(posedge in_clk);
		if (result_count != accepted_count - flushed_count) begin
			$display("%0d results seen for %0d accepted pushes not flushed by reset",
				result_count, accepted_count - flushed_count);
			fail_count++;
		end
		$display("tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: verification/div_vectors.txt
# columns: group dividend divisor quotient remainder div_zero, all hex
# the unit is reset before each new group
0 64 07 0e 02 0
0 ff 01 ff 00 0
0 05 09 00 05 0
0 00 03 00 00 0
0 2a 00 ff 2a 1
0 c8 0a 14 00 0
0 11 11 01 00 0
0 ff ff 01 00 0
0 80 03 2a 02 0
0 00 00 ff 00 1
0 fe 02 7f 00 0
0 63 0c 08 03 0
1 ff 00 ff ff 1
1 ff 10 0f 0f 0
1 01 02 00 01 0
1 e7 0d 11 0a 0
1 7b 01 7b 00 0
1 40 40 01 00 0
1 c3 07 1b 06 0
1 09 03 03 00 0
1 ff 02 7f 01 0

// File: verilog.f
+incdir+rtl
rtl/div_pkg.sv
rtl/ripple_carry_adder.sv
rtl/divider.sv
rtl/operand_fifo.sv
rtl/div_issue.sv
rtl/div_unit.sv
verification/div_unit_properties.sv
verification/div_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= div_unit_tb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
